//--- rtl/icache_pkg.sv
package icache_pkg;

   // Port widths
   localparam int unsigned FETCH_ADDR_WIDTH  = 32;
   localparam int unsigned FETCH_DATA_WIDTH  = 32;
   localparam int unsigned REFILL_DATA_WIDTH = 128;   // One full line per refill

   // Cache geometry
   localparam int unsigned CACHE_SIZE   = 256;                                // Bytes
   localparam int unsigned NB_LINES     = CACHE_SIZE / (REFILL_DATA_WIDTH / 8); // 16 lines
   localparam int unsigned OFFSET_WIDTH = $clog2(REFILL_DATA_WIDTH / 8);      // Byte in line
   localparam int unsigned INDEX_WIDTH  = $clog2(NB_LINES);
   localparam int unsigned TAG_WIDTH    = FETCH_ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

   // Split of the line offset into word select and byte bits
   localparam int unsigned BYTE_SEL_WIDTH = $clog2(FETCH_DATA_WIDTH / 8);
   localparam int unsigned WORD_SEL_WIDTH = OFFSET_WIDTH - BYTE_SEL_WIDTH;   // Bits 3:2

   typedef logic [REFILL_DATA_WIDTH-1:0] line_t;
   typedef logic [TAG_WIDTH-1:0]         tag_t;

   // Fetch address, seen either as lookup fields or as line number plus offset
   typedef union packed
   {
      struct packed
      {
         tag_t                      tag;
         logic [INDEX_WIDTH-1:0]    index;
         logic [WORD_SEL_WIDTH-1:0] word_sel;   // Word within the line
         logic [BYTE_SEL_WIDTH-1:0] byte_sel;   // Ignored, fetches are word aligned
      } fields;
      struct packed
      {
         logic [FETCH_ADDR_WIDTH-OFFSET_WIDTH-1:0] line_num;
         logic [OFFSET_WIDTH-1:0]                  offset;
      } line;
   } icache_addr_u;

endpackage

//--- rtl/icache_array_if.sv
`timescale 1ns/1ps

interface icache_array_if;
   import icache_pkg::*;

   // Lookup and write select
   logic [INDEX_WIDTH-1:0] index;

   // Line write, lands at the next edge
   logic                   wr_en;
   tag_t                   wr_tag;
   line_t                  wr_line;

   // Combinational read of the indexed line
   logic                   rd_valid;
   tag_t                   rd_tag;
   line_t                  rd_line;

   logic                   clear_all;   // Drops every valid bit at the next edge

   modport ctrl
   (
      output index, wr_en, wr_tag, wr_line, clear_all,
      input  rd_valid, rd_tag, rd_line
   );

   modport store
   (
      input  index, wr_en, wr_tag, wr_line, clear_all,
      output rd_valid, rd_tag, rd_line
   );

endinterface

//--- rtl/icache_line_store.sv
`timescale 1ns/1ps

module icache_line_store
(
   input  logic          clk,
   input  logic          arst_n_i,

   icache_array_if.store array      // Port towards the controller
);
   import icache_pkg::*;

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////
   logic [NB_LINES-1:0] valid_q;           // One bit per line
   tag_t                tag_q  [NB_LINES];
   line_t               line_q [NB_LINES];

   // Valid bits, the only state cleared by reset
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_q <= '0;
      end
      else if (array.clear_all)
      begin
         valid_q <= '0;                    // Whole-cache flush
      end
      else if (array.wr_en)
      begin
         valid_q[array.index] <= 1'b1;     // Refilled line becomes usable
      end
   end

   // Tag and data payload
   always_ff @(posedge clk)
   begin
      if (array.wr_en)
      begin
         tag_q[array.index]  <= array.wr_tag;
         line_q[array.index] <= array.wr_line;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read side, combinational from the index
   ////////////////////////////////////////////////////////////
   assign array.rd_valid = valid_q[array.index];
   assign array.rd_tag   = tag_q[array.index];
   assign array.rd_line  = line_q[array.index];

endmodule

//--- rtl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
(
   input  logic                                    clk,
   input  logic                                    arst_n_i,

   // Processor fetch port
   input  logic                                    fetch_req_i,
   input  logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] fetch_addr_i,
   output logic                                    fetch_gnt_o,
   output logic                                    fetch_rvalid_o,
   output logic [icache_pkg::FETCH_DATA_WIDTH-1:0] fetch_rdata_o,

   input  logic                                    flush_icache_i,
   output logic                                    cache_is_flushed_o,

   icache_array_if.ctrl                            array,

   // Refill request, towards the request buffer
   output logic                                    req_valid_o,
   input  logic                                    req_grant_i,
   output logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] req_addr_o,

   // Refill response, from the response buffer
   input  logic                                    resp_valid_i,
   input  icache_pkg::line_t                       resp_line_i
);
   import icache_pkg::*;

   localparam logic S_LOOKUP = 1'b0;   // Serving hits, issuing misses
   localparam logic S_REFILL = 1'b1;   // One refill outstanding

   logic                        state_q, state_d;
   icache_addr_u                fetch_u;          // Decoded fetch address
   icache_addr_u                miss_q;           // Address of the line being refilled
   icache_addr_u                line_addr;        // Aligned refill address
   logic                        hit;
   logic                        miss;
   logic                        do_clear;
   logic                        flush_pend_q;     // Flush seen during a refill
   logic                        flushed_q;
   logic                        rvalid_q;
   logic [FETCH_DATA_WIDTH-1:0] rdata_q;

   ////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////
   assign fetch_u     = fetch_addr_i;
   assign array.index = (state_q == S_REFILL) ? miss_q.fields.index : fetch_u.fields.index;

   assign hit  = fetch_req_i && (state_q == S_LOOKUP) && array.rd_valid
                 && (array.rd_tag == fetch_u.fields.tag);
   assign miss = fetch_req_i && (state_q == S_LOOKUP) && !hit;

   assign fetch_gnt_o = hit;              // Same cycle as the request

   // Line number kept, offset forced to zero
   always_comb
   begin
      line_addr               = fetch_u;
      line_addr.line.offset   = '0;
   end

   assign req_valid_o = miss;             // Pushed once, then we leave lookup
   assign req_addr_o  = line_addr;

   // Line write when the response arrives
   assign array.wr_en   = (state_q == S_REFILL) && resp_valid_i;
   assign array.wr_tag  = miss_q.fields.tag;
   assign array.wr_line = resp_line_i;

   // Flush only acts outside a refill
   assign do_clear        = (state_q == S_LOOKUP) && (flush_icache_i || flush_pend_q);
   assign array.clear_all = do_clear;

   ////////////////////////////////////////////////////////////
   // Miss FSM
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_LOOKUP : if (miss && req_grant_i) state_d = S_REFILL;
         S_REFILL : if (resp_valid_i)        state_d = S_LOOKUP;   // Line written this edge
         default  : state_d = S_LOOKUP;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q      <= S_LOOKUP;
         flush_pend_q <= 1'b0;
         flushed_q    <= 1'b1;              // Everything invalid out of reset
         rvalid_q     <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         rvalid_q <= hit;                   // Data one cycle after the grant

         if (do_clear)
            flush_pend_q <= 1'b0;
         else if (flush_icache_i)
            flush_pend_q <= 1'b1;           // Hold it until the refill is done

         if (do_clear)
            flushed_q <= 1'b1;
         else if (array.wr_en)
            flushed_q <= 1'b0;
      end
   end

   // Payload registers
   always_ff @(posedge clk)
   begin
      if (miss && req_grant_i)
         miss_q <= fetch_u;
      if (hit)
         rdata_q <= array.rd_line[fetch_u.fields.word_sel*FETCH_DATA_WIDTH +: FETCH_DATA_WIDTH];
   end

   assign fetch_rvalid_o     = rvalid_q;
   assign fetch_rdata_o      = rdata_q;
   assign cache_is_flushed_o = flushed_q;

endmodule

//--- rtl/refill_fifo.sv
`timescale 1ns/1ps

module refill_fifo
#(
   parameter int unsigned DATA_WIDTH = 32,
   parameter int unsigned DATA_DEPTH = 2
)
(
   input  logic                  clk,
   input  logic                  arst_n_i,

   // Push side
   input  logic [DATA_WIDTH-1:0] data_i,
   input  logic                  valid_i,
   output logic                  grant_o,

   // Pop side
   output logic [DATA_WIDTH-1:0] data_o,
   output logic                  valid_o,
   input  logic                  grant_i
);

   localparam int unsigned PTR_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DATA_DEPTH + 1);

   logic [DATA_WIDTH-1:0] mem_q [DATA_DEPTH];   // Entry storage
   logic [PTR_W-1:0]      wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0]      cnt_q;                // Occupancy
   logic                  push, pop;

   assign grant_o = (cnt_q != CNT_W'(DATA_DEPTH));   // Room left
   assign valid_o = (cnt_q != '0);                   // Something to pop
   assign data_o  = mem_q[rd_ptr_q];

   assign push = valid_i && grant_o;
   assign pop  = valid_o && grant_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (push)   // Wrap at the last entry
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DATA_DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
         if (pop)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DATA_DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
         if (push && !pop)
            cnt_q <= cnt_q + CNT_W'(1);
         else if (pop && !push)
            cnt_q <= cnt_q - CNT_W'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem_q[wr_ptr_q] <= data_i;
   end

endmodule

//--- rtl/pri_icache.sv
`timescale 1ns/1ps

module pri_icache
(
   input  logic                                     clk,
   input  logic                                     arst_n_i,

   // Processor fetch port
   input  logic                                     fetch_req_i,
   input  logic [icache_pkg::FETCH_ADDR_WIDTH-1:0]  fetch_addr_i,
   output logic                                     fetch_gnt_o,
   output logic                                     fetch_rvalid_o,
   output logic [icache_pkg::FETCH_DATA_WIDTH-1:0]  fetch_rdata_o,

   // Refill port
   output logic                                     refill_req_o,
   input  logic                                     refill_gnt_i,
   output logic [icache_pkg::FETCH_ADDR_WIDTH-1:0]  refill_addr_o,
   input  logic                                     refill_r_valid_i,
   input  logic [icache_pkg::REFILL_DATA_WIDTH-1:0] refill_r_data_i,

   input  logic                                     flush_icache_i,
   output logic                                     cache_is_flushed_o
);
   import icache_pkg::*;

   logic                        req_valid;    // Controller to request buffer
   logic                        req_grant;
   logic [FETCH_ADDR_WIDTH-1:0] req_addr;
   logic                        resp_valid;   // Response buffer to controller
   line_t                       resp_line;

   icache_array_if array_bus ();

   ////////////////////////////////////////////////////////////
   // Controller and line store
   ////////////////////////////////////////////////////////////
   icache_ctrl i_icache_ctrl
   (
      .clk                ( clk                ),
      .arst_n_i           ( arst_n_i           ),
      .fetch_req_i        ( fetch_req_i        ),
      .fetch_addr_i       ( fetch_addr_i       ),
      .fetch_gnt_o        ( fetch_gnt_o        ),
      .fetch_rvalid_o     ( fetch_rvalid_o     ),
      .fetch_rdata_o      ( fetch_rdata_o      ),
      .flush_icache_i     ( flush_icache_i     ),
      .cache_is_flushed_o ( cache_is_flushed_o ),
      .array              ( array_bus.ctrl     ),
      .req_valid_o        ( req_valid          ),
      .req_grant_i        ( req_grant          ),
      .req_addr_o         ( req_addr           ),
      .resp_valid_i       ( resp_valid         ),
      .resp_line_i        ( resp_line          )
   );

   icache_line_store i_line_store
   (
      .clk      ( clk             ),
      .arst_n_i ( arst_n_i        ),
      .array    ( array_bus.store )
   );

   ////////////////////////////////////////////////////////////
   // Refill buffers
   ////////////////////////////////////////////////////////////
   refill_fifo
   #(
      .DATA_WIDTH ( FETCH_ADDR_WIDTH ),
      .DATA_DEPTH ( 2                )
   )
   refill_req_buffer
   (
      .clk      ( clk           ),
      .arst_n_i ( arst_n_i      ),
      .data_i   ( req_addr      ),
      .valid_i  ( req_valid     ),
      .grant_o  ( req_grant     ),
      .data_o   ( refill_addr_o ),
      .valid_o  ( refill_req_o  ),
      .grant_i  ( refill_gnt_i  )
   );

   refill_fifo
   #(
      .DATA_WIDTH ( REFILL_DATA_WIDTH ),
      .DATA_DEPTH ( 2                 )
   )
   refill_resp_buffer
   (
      .clk      ( clk              ),
      .arst_n_i ( arst_n_i         ),
      .data_i   ( refill_r_data_i  ),
      .valid_i  ( refill_r_valid_i ),
      .grant_o  (                  ),   // Memory side does not wait
      .data_o   ( resp_line        ),
      .valid_o  ( resp_valid       ),
      .grant_i  ( 1'b1             )    // Controller always takes the line
   );

endmodule

//--- test/icache_properties.sv
`timescale 1ns/1ps

module icache_properties
(
   input logic                                    clk,
   input logic                                    arst_n_i,
   input logic                                    fetch_gnt_i,
   input logic                                    fetch_rvalid_i,
   input logic                                    refill_req_i,
   input logic                                    refill_gnt_i,
   input logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] refill_addr_i
);
   import icache_pkg::*;

   int unsigned fail_count = 0;   // Assertion failures so far

   // Read data exactly one cycle after each grant
   a_rvalid_after_gnt : assert property (@(posedge clk) disable iff (!arst_n_i)
      fetch_gnt_i |=> fetch_rvalid_i)
      else
      begin
         fail_count++;
         $error("fetch_rvalid_o missing one cycle after fetch_gnt_o");
      end

   a_refill_aligned : assert property (@(posedge clk) disable iff (!arst_n_i)
      refill_req_i |-> (refill_addr_i[OFFSET_WIDTH-1:0] == '0))
      else
      begin
         fail_count++;
         $error("refill_addr_o not aligned to a line");
      end

   // Request held until the memory side takes it
   a_refill_stable : assert property (@(posedge clk) disable iff (!arst_n_i)
      (refill_req_i && !refill_gnt_i) |=> (refill_req_i && $stable(refill_addr_i)))
      else
      begin
         fail_count++;
         $error("refill request dropped or address changed before grant");
      end

endmodule

bind pri_icache icache_properties u_properties
(
   .clk            ( clk            ),
   .arst_n_i       ( arst_n_i       ),
   .fetch_gnt_i    ( fetch_gnt_o    ),
   .fetch_rvalid_i ( fetch_rvalid_o ),
   .refill_req_i   ( refill_req_o   ),
   .refill_gnt_i   ( refill_gnt_i   ),
   .refill_addr_i  ( refill_addr_o  )
);

//--- test/tb_common.svh
// Reference memory content, each word derived from its own word address
function automatic logic [31:0] mem_word(input logic [31:0] addr);
   return {addr[31:2], 2'b00} ^ 32'hC3A5_5A3C;
endfunction

// Labels used in error lines
function automatic string test_name(input logic [2:0] id);
   case (id)
      3'd1    : return "cold_fetch";
      3'd2    : return "line_hits";
      3'd3    : return "index_conflict";
      3'd4    : return "flush";
      3'd5    : return "random_fetch";
      default : return "reset";
   endcase
endfunction

//--- test/icache_checker.sv
`timescale 1ns/1ps

module icache_checker
(
   input  logic                                    clk,
   input  logic                                    arst_n_i,
   input  logic [2:0]                              test_id_i,        // Current test, for messages

   // Fetch port as seen by the DUT
   input  logic                                    fetch_gnt_i,
   input  logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] fetch_addr_i,
   input  logic                                    fetch_rvalid_i,
   input  logic [icache_pkg::FETCH_DATA_WIDTH-1:0] fetch_rdata_i,

   // Refill request handshake
   input  logic                                    refill_req_i,
   input  logic                                    refill_gnt_i,
   input  logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] refill_addr_i,

   output int unsigned                             error_count_o,
   output int unsigned                             refill_count_o,
   output logic [icache_pkg::FETCH_ADDR_WIDTH-1:0] last_refill_addr_o
);
   import icache_pkg::*;

   `include "tb_common.svh"

   logic                        pending;        // Grant seen one cycle ago
   logic [FETCH_ADDR_WIDTH-1:0] pending_addr;   // Its address
   logic [FETCH_DATA_WIDTH-1:0] expected;

   // Falling edge, all DUT outputs settled here
   always @(negedge clk)
   begin
      if (!arst_n_i)
      begin
         pending            = 1'b0;
         pending_addr       = '0;
         error_count_o      = 0;
         refill_count_o     = 0;
         last_refill_addr_o = '0;
      end
      else
      begin
         if (fetch_rvalid_i && !pending)
         begin
            error_count_o++;
            $display("Read data returned with no outstanding grant (test %s)",
                     test_name(test_id_i));
         end
         if (pending && !fetch_rvalid_i)
         begin
            error_count_o++;
            $display("Grant for 0x%08h not followed by read data in the next cycle (test %s)",
                     pending_addr, test_name(test_id_i));
         end
         if (pending && fetch_rvalid_i)
         begin
            expected = mem_word(pending_addr);
            if (fetch_rdata_i !== expected)
            begin
               error_count_o++;
               $display("ERROR [%s] fetch 0x%08h: expected 0x%08h, actual 0x%08h",
                        test_name(test_id_i), pending_addr, expected, fetch_rdata_i);
            end
         end
         pending      = fetch_gnt_i;           // Checked on the next falling edge
         pending_addr = fetch_addr_i;

         // Refill handshake
         if (refill_req_i && refill_gnt_i)
         begin
            refill_count_o++;
            last_refill_addr_o = refill_addr_i;
            if (refill_addr_i[OFFSET_WIDTH-1:0] != '0)
            begin
               error_count_o++;
               $display("Refill address 0x%08h is not aligned to a line (test %s)",
                        refill_addr_i, test_name(test_id_i));
            end
         end
      end
   end

endmodule

//--- test/tb_pri_icache.sv
`timescale 1ns/1ps

module tb_pri_icache;
   import icache_pkg::*;

   `include "tb_common.svh"

   localparam int unsigned RESET_CYCLES = 10;
   localparam int unsigned NUM_FETCHES  = 1 + 4 + 3 + 2 + 200;   // Fetches over all tests
   localparam int unsigned MAX_CYCLES   = NUM_FETCHES * 20 + RESET_CYCLES;

   localparam logic [FETCH_ADDR_WIDTH-1:0] ADDR_A = 32'h0000_1238;   // Index 3, word 2
   localparam logic [FETCH_ADDR_WIDTH-1:0] ADDR_B = 32'h0000_2054;   // Index 5
   localparam logic [FETCH_ADDR_WIDTH-1:0] ADDR_C = 32'h0000_5058;   // Index 5, other tag

   logic                        clk;
   logic                        arst_n_i;
   logic                        fetch_req_i;
   logic [FETCH_ADDR_WIDTH-1:0] fetch_addr_i;
   logic                        fetch_gnt_o;
   logic                        fetch_rvalid_o;
   logic [FETCH_DATA_WIDTH-1:0] fetch_rdata_o;
   logic                        refill_req_o;
   logic                        refill_gnt_i;
   logic [FETCH_ADDR_WIDTH-1:0] refill_addr_o;
   logic                        refill_r_valid_i;
   line_t                       refill_r_data_i;
   logic                        flush_icache_i;
   logic                        cache_is_flushed_o;

   logic [2:0]                  test_id;
   int unsigned                 data_errors;       // From the checker
   int unsigned                 scen_errors;       // Sequence level checks here
   int unsigned                 refill_count;
   logic [FETCH_ADDR_WIDTH-1:0] last_refill_addr;
   int unsigned                 cycle_cnt;

   pri_icache UUT
   (
      .clk                ( clk                ),
      .arst_n_i           ( arst_n_i           ),
      .fetch_req_i        ( fetch_req_i        ),
      .fetch_addr_i       ( fetch_addr_i       ),
      .fetch_gnt_o        ( fetch_gnt_o        ),
      .fetch_rvalid_o     ( fetch_rvalid_o     ),
      .fetch_rdata_o      ( fetch_rdata_o      ),
      .refill_req_o       ( refill_req_o       ),
      .refill_gnt_i       ( refill_gnt_i       ),
      .refill_addr_o      ( refill_addr_o      ),
      .refill_r_valid_i   ( refill_r_valid_i   ),
      .refill_r_data_i    ( refill_r_data_i    ),
      .flush_icache_i     ( flush_icache_i     ),
      .cache_is_flushed_o ( cache_is_flushed_o )
   );

   icache_checker u_checker
   (
      .clk                ( clk              ),
      .arst_n_i           ( arst_n_i         ),
      .test_id_i          ( test_id          ),
      .fetch_gnt_i        ( fetch_gnt_o      ),
      .fetch_addr_i       ( fetch_addr_i     ),
      .fetch_rvalid_i     ( fetch_rvalid_o   ),
      .fetch_rdata_i      ( fetch_rdata_o    ),
      .refill_req_i       ( refill_req_o     ),
      .refill_gnt_i       ( refill_gnt_i     ),
      .refill_addr_i      ( refill_addr_o    ),
      .error_count_o      ( data_errors      ),
      .refill_count_o     ( refill_count     ),
      .last_refill_addr_o ( last_refill_addr )
   );

   ////////////////////////////////////////////////////////////
   // Clock and timeout
   ////////////////////////////////////////////////////////////
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Memory model on the refill port
   ////////////////////////////////////////////////////////////
   function automatic line_t fill_line(input logic [FETCH_ADDR_WIDTH-1:0] base);
      line_t line;
      for (int w = 0; w < 4; w++)
         line[w*FETCH_DATA_WIDTH +: FETCH_DATA_WIDTH] = mem_word(base + 32'(w * 4));
      return line;
   endfunction

   initial
   begin
      logic [FETCH_ADDR_WIDTH-1:0] line_addr;
      int unsigned                 delay;
      refill_gnt_i     = 1'b0;
      refill_r_valid_i = 1'b0;
      refill_r_data_i  = '0;
      wait (arst_n_i);
      forever
      begin
         @(posedge clk);
         #1;
         if (refill_req_o)
         begin
            delay = $urandom_range(3, 0);   // Grant latency
            repeat (delay)
            begin
               @(posedge clk);
               #1;
            end
            line_addr    = refill_addr_o;
            refill_gnt_i = 1'b1;
            @(posedge clk);
            #1;
            refill_gnt_i = 1'b0;
            delay = $urandom_range(4, 1);   // Response latency after the grant
            repeat (delay - 1)
            begin
               @(posedge clk);
               #1;
            end
            refill_r_valid_i = 1'b1;
            refill_r_data_i  = fill_line(line_addr);
            @(posedge clk);
            #1;
            refill_r_valid_i = 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus driven 1 ns after the rising edge
   ////////////////////////////////////////////////////////////
   task automatic check_equal(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         scen_errors++;
         $display("ERROR [%s] %s: expected 0x%08h, actual 0x%08h",
                  test_name(test_id), what, expected, actual);
      end
   endtask

   // Holds the request until granted and counts the cycles spent waiting
   task automatic fetch_word(input logic [FETCH_ADDR_WIDTH-1:0] addr,
                             output int unsigned waits);
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      waits        = 0;
      @(negedge clk);
      while (!fetch_gnt_o)
      begin
         waits++;
         @(negedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic release_fetch(input int unsigned idle_cycles);
      fetch_req_i = 1'b0;
      repeat (idle_cycles)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   initial
   begin
      logic [FETCH_ADDR_WIDTH-1:0] addr;
      int unsigned                 waits;
      int unsigned                 refills_before;
      void'($urandom(4372));
      arst_n_i       = 1'b0;
      fetch_req_i    = 1'b0;
      fetch_addr_i   = '0;
      flush_icache_i = 1'b0;
      test_id        = 3'd0;
      scen_errors    = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n_i = 1'b1;
      check_equal("flushed after reset", 1, 32'(cache_is_flushed_o));

      // Cold miss needs one aligned refill
      test_id        = 3'd1;
      refills_before = refill_count;
      fetch_word(ADDR_A, waits);
      release_fetch(2);
      check_equal("refill count", 1, refill_count - refills_before);
      check_equal("refill address", ADDR_A & 32'hFFFF_FFF0, last_refill_addr);

      // All four words of the filled line back to back
      test_id        = 3'd2;
      refills_before = refill_count;
      for (int i = 0; i < 4; i++)
      begin
         fetch_word((ADDR_A & 32'hFFFF_FFF0) + 32'(i * 4), waits);
         check_equal("grant wait cycles", 0, waits);
      end
      release_fetch(2);
      check_equal("refill count", 0, refill_count - refills_before);

      // Two tags on one index evict each other
      test_id        = 3'd3;
      refills_before = refill_count;
      fetch_word(ADDR_B, waits);
      fetch_word(ADDR_C, waits);
      fetch_word(ADDR_B, waits);
      release_fetch(2);
      check_equal("refill count", 3, refill_count - refills_before);

      // Flush drops the cached line
      test_id        = 3'd4;
      refills_before = refill_count;
      fetch_word(ADDR_A, waits);
      release_fetch(2);
      check_equal("refill count before flush", 0, refill_count - refills_before);
      check_equal("flushed before flush", 0, 32'(cache_is_flushed_o));
      flush_icache_i = 1'b1;
      @(posedge clk);
      #1;
      flush_icache_i = 1'b0;
      check_equal("flushed after flush", 1, 32'(cache_is_flushed_o));
      fetch_word(ADDR_A, waits);
      release_fetch(2);
      check_equal("refill count after flush", 1, refill_count - refills_before);
      check_equal("flushed after refill", 0, 32'(cache_is_flushed_o));

      // Random mix of hits and misses over 4 tags and 16 lines
      test_id = 3'd5;
      repeat (200)
      begin
         addr = 32'h0004_0000 | ($urandom_range(3, 0) << 12) | ($urandom_range(15, 0) << 4)
                | ($urandom_range(3, 0) << 2);
         fetch_word(addr, waits);
      end
      release_fetch(4);

      $display("Errors: %0d data, %0d sequence, %0d assertion", data_errors, scen_errors,
               UUT.u_properties.fail_count);
      if (data_errors + scen_errors + UUT.u_properties.fail_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- filelist.f
+incdir+test
rtl/icache_pkg.sv
rtl/icache_array_if.sv
rtl/icache_line_store.sv
rtl/icache_ctrl.sv
rtl/refill_fifo.sv
rtl/pri_icache.sv
test/icache_properties.sv
test/icache_checker.sv
test/tb_pri_icache.sv

//--- Makefile
TOP := tb_pri_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "Test passed" > /dev/null

clean:
	rm -rf obj_dir
